/* common/dma_pkg.sv */
// Fixed 32-bit AHB-Lite word and single transfers only, so HSIZE, HBURST, HPROT and HRESP are absent
package dma_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int dma_addr_w = 32;  // AHB-Lite address
  localparam int dma_data_w = 32;  // AHB-Lite word
  localparam int dma_len_w  = 16;  // Word count per descriptor

  typedef logic [dma_addr_w-1:0] dma_addr_t;
  typedef logic [dma_data_w-1:0] dma_data_t;

  //////////////////////////////////////////////////
  // Register map, one 16-byte window per entry
  //////////////////////////////////////////////////

  localparam logic [3:0] reg_src  = 4'h0;  // Source address
  localparam logic [3:0] reg_dst  = 4'h4;  // Destination address
  localparam logic [3:0] reg_len  = 4'h8;  // Length in words
  localparam logic [3:0] reg_ctrl = 4'hc;  // Start, clear and flags

  localparam int ctrl_start = 0;  // Write 1 to queue the entry
  localparam int ctrl_clear = 1;  // Write 1 to drop done

  // HTRANS codes in use
  localparam logic [1:0] htrans_idle   = 2'b00;
  localparam logic [1:0] htrans_nonseq = 2'b10;

  //////////////////////////////////////////////////
  // Shared structs
  //////////////////////////////////////////////////

  typedef struct packed {
    dma_addr_t             src;  // First source word
    dma_addr_t             dst;  // First destination word
    logic [dma_len_w-1:0]  len;  // Words to copy
  } dma_req_t;

  // Master-to-slave half of an AHB-Lite port
  typedef struct packed {
    logic       hsel;
    dma_addr_t  haddr;
    logic       hwrite;
    logic [1:0] htrans;
    dma_data_t  hwdata;  // Valid in the data phase
  } ahb_req_t;

endpackage

/* dma_engine/dma_word_counter.sv */
`timescale 1ns/1ns
// Load takes priority over decrement and the count does not wrap below zero
module dma_word_counter import dma_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 load,
  input  logic [dma_len_w-1:0] len,
  input  logic                 dec,
  output logic                 zero
);

  logic [dma_len_w-1:0] count;  // Words still to write

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (load) begin
      count <= len;
    end else if (dec) begin
      count <= count - 1'b1;
    end
  end

  assign zero = (count == '0);  // Last word already counted

  a_no_dec_at_zero: assert property (@(posedge clk) disable iff (rst)
    dec |-> !zero)
    else $error("word counter decremented below zero");

endmodule

/* dma_engine/dma_ahb_master.sv */
`timescale 1ns/1ns
// Single NONSEQ word transfers only, start is ignored while busy and HRESP is not checked
module dma_ahb_master import dma_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  logic      write,
  input  dma_addr_t addr,
  input  dma_data_t wdata,
  output logic      done,
  output dma_data_t rdata,
  output ahb_req_t  mem_req,
  input  dma_data_t mem_hrdata,
  input  logic      mem_hready
);

  typedef enum logic [1:0] {ph_idle, ph_addr, ph_data} phase_t;

  phase_t    phase;
  logic      write_q;
  dma_addr_t addr_q;
  dma_data_t wdata_q;

  //////////////////////////////////////////////////
  // Phase sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= ph_idle;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;  // Single-cycle pulse
      case (phase)
        ph_idle: if (start) phase <= ph_addr;
        ph_addr: if (mem_hready) phase <= ph_data;  // Slave took the address
        ph_data: begin
          if (mem_hready) begin
            phase <= ph_idle;
            done  <= 1'b1;
          end
        end
        default: phase <= ph_idle;
      endcase
    end
  end

  // Request and read data capture
  always_ff @(posedge clk) begin
    if (phase == ph_idle && start) begin
      addr_q  <= addr;
      write_q <= write;
      wdata_q <= wdata;
    end
    if (phase == ph_data && mem_hready && !write_q) begin
      rdata <= mem_hrdata;  // Held until the next read
    end
  end

  always_comb begin
    mem_req.hsel   = (phase == ph_addr);
    mem_req.haddr  = addr_q;
    mem_req.hwrite = write_q;
    mem_req.htrans = (phase == ph_addr) ? htrans_nonseq : htrans_idle;
    mem_req.hwdata = wdata_q;  // Stable through the data phase
  end

  a_haddr_stable: assert property (@(posedge clk) disable iff (rst)
    (phase == ph_addr && !mem_hready) |=> $stable(mem_req.haddr))
    else $error("haddr changed during a stalled address phase");

endmodule

/* dma_engine/dma_ctrl_fsm.sv */
`timescale 1ns/1ns
// Lowest valid entry wins, one word in flight, and addresses advance by 4 with no wrap check
module dma_ctrl_fsm import dma_pkg::*; #(
  parameter  int TABLE_ENTRIES = 4,
  localparam int idx_w = (TABLE_ENTRIES > 1) ? $clog2(TABLE_ENTRIES) : 1
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [TABLE_ENTRIES-1:0] valid,
  output logic [idx_w-1:0]         sel_idx,
  input  dma_req_t                 sel_req,
  output logic                     cnt_load,
  output logic                     cnt_dec,
  input  logic                     cnt_zero,
  output logic                     xfer_start,
  output logic                     xfer_write,
  output dma_addr_t                xfer_addr,
  output dma_data_t                xfer_wdata,
  input  logic                     xfer_done,
  input  dma_data_t                xfer_rdata,
  output logic                     done_en,
  output logic [idx_w-1:0]         done_idx
);

  typedef enum logic [2:0] {st_idle, st_load, st_read, st_write, st_finish} state_t;

  state_t           state;
  logic             busy;       // Master owns a transfer
  logic [idx_w-1:0] pick_idx;   // Lowest set bit of valid
  logic [idx_w-1:0] sel_idx_q;
  dma_addr_t        src_q;
  dma_addr_t        dst_q;
  dma_data_t        data_q;     // Word between read and write

  // Priority pick, low index first
  always_comb begin
    pick_idx = '0;
    for (int i = TABLE_ENTRIES - 1; i >= 0; i--) begin
      if (valid[i]) begin
        pick_idx = idx_w'(i);
      end
    end
  end

  //////////////////////////////////////////////////
  // State and handshake
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      busy  <= 1'b0;
    end else begin
      if (xfer_start) begin
        busy <= 1'b1;
      end else if (xfer_done) begin
        busy <= 1'b0;
      end
      case (state)
        st_idle:   if (|valid) state <= st_load;
        st_load:   state <= (sel_req.len == '0) ? st_finish : st_read;  // Empty copy skips the bus
        st_read:   if (xfer_done) state <= st_write;
        st_write:  if (xfer_done) state <= cnt_zero ? st_finish : st_read;
        st_finish: state <= st_idle;
        default:   state <= st_idle;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (state == st_idle) begin
      sel_idx_q <= pick_idx;
    end
    if (state == st_load) begin
      src_q <= sel_req.src;
      dst_q <= sel_req.dst;
    end
    if (state == st_read && xfer_done) begin
      data_q <= xfer_rdata;
      src_q  <= src_q + dma_addr_w'(4);  // Next source word
    end
    if (state == st_write && xfer_done) begin
      dst_q <= dst_q + dma_addr_w'(4);
    end
  end

  assign sel_idx    = sel_idx_q;
  assign cnt_load   = (state == st_load);
  assign xfer_start = (state == st_read || state == st_write) && !busy;
  assign xfer_write = (state == st_write);
  assign cnt_dec    = xfer_start && xfer_write;  // Count settles before the write ends
  assign xfer_addr  = xfer_write ? dst_q : src_q;
  assign xfer_wdata = data_q;
  assign done_en    = (state == st_finish);
  assign done_idx   = sel_idx_q;

  a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
    xfer_start |=> (!xfer_start throughout xfer_done [->1]))
    else $error("transfer started while master busy");

endmodule

/* hw/dma_cfg_slave.sv */
`timescale 1ns/1ns
// Zero wait states and no error response, and addresses past the last entry are not decoded
module dma_cfg_slave import dma_pkg::*; #(
  parameter  int TABLE_ENTRIES = 4,
  localparam int idx_w = (TABLE_ENTRIES > 1) ? $clog2(TABLE_ENTRIES) : 1
) (
  input  logic             clk,
  input  logic             rst,
  input  ahb_req_t         cfg_req,
  output dma_data_t        cfg_hrdata,
  output logic             cfg_hready,
  output logic             tbl_wr_en,
  output logic [idx_w-1:0] tbl_wr_idx,
  output logic [1:0]       tbl_wr_field,
  output dma_data_t        tbl_wr_data,
  output logic [idx_w-1:0] tbl_rd_idx,
  input  dma_req_t         tbl_rd_req,
  input  logic [1:0]       tbl_rd_flags
);

  logic             addr_phase;  // Valid address phase this cycle
  logic             ap_valid;    // Data phase pending
  logic             ap_write;
  logic [idx_w-1:0] ap_idx;
  logic [1:0]       ap_field;

  assign addr_phase = cfg_req.hsel && (cfg_req.htrans == htrans_nonseq);
  assign cfg_hready = 1'b1;  // Never stalls

  always_ff @(posedge clk) begin
    if (rst) begin
      ap_valid <= 1'b0;
    end else begin
      ap_valid <= addr_phase;
    end
  end

  // Address phase capture
  always_ff @(posedge clk) begin
    if (addr_phase) begin
      ap_write <= cfg_req.hwrite;
      ap_idx   <= cfg_req.haddr[4 +: idx_w];  // Entry is haddr / 16
      ap_field <= cfg_req.haddr[3:2];         // Word within the window
    end
  end

  //////////////////////////////////////////////////
  // Data phase
  //////////////////////////////////////////////////

  assign tbl_wr_en    = ap_valid && ap_write;
  assign tbl_wr_idx   = ap_idx;
  assign tbl_wr_field = ap_field;
  assign tbl_wr_data  = cfg_req.hwdata;  // Write data arrives now
  assign tbl_rd_idx   = ap_idx;

  always_comb begin
    case (ap_field)
      reg_src[3:2]: cfg_hrdata = tbl_rd_req.src;
      reg_dst[3:2]: cfg_hrdata = tbl_rd_req.dst;
      reg_len[3:2]: cfg_hrdata = dma_data_w'(tbl_rd_req.len);
      default:      cfg_hrdata = dma_data_w'(tbl_rd_flags);  // Control word
    endcase
  end

  a_entry_in_range: assert property (@(posedge clk) disable iff (rst)
    addr_phase |-> (cfg_req.haddr[dma_addr_w-1:4] < TABLE_ENTRIES))
    else $error("config access beyond last table entry");

endmodule

/* hw/dma_request_table.sv */
`timescale 1ns/1ns
// Descriptors have no reset and must be written before start, and irq is level and stays until clear
module dma_request_table import dma_pkg::*; #(
  parameter  int TABLE_ENTRIES = 4,
  localparam int idx_w = (TABLE_ENTRIES > 1) ? $clog2(TABLE_ENTRIES) : 1
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     tbl_wr_en,
  input  logic [idx_w-1:0]         tbl_wr_idx,
  input  logic [1:0]               tbl_wr_field,
  input  dma_data_t                tbl_wr_data,
  input  logic [idx_w-1:0]         tbl_rd_idx,
  output dma_req_t                 tbl_rd_req,
  output logic [1:0]               tbl_rd_flags,
  input  logic [idx_w-1:0]         sel_idx,
  output dma_req_t                 sel_req,
  output logic [TABLE_ENTRIES-1:0] valid,
  input  logic                     done_en,
  input  logic [idx_w-1:0]         done_idx,
  output logic [TABLE_ENTRIES-1:0] irq
);

  dma_req_t                 req_mem [TABLE_ENTRIES];  // Descriptor storage
  logic [TABLE_ENTRIES-1:0] valid_q;                  // Queued, not yet copied
  logic [TABLE_ENTRIES-1:0] done_q;                   // Copy finished
  logic                     ctrl_wr;

  assign ctrl_wr = tbl_wr_en && (tbl_wr_field == reg_ctrl[3:2]);

  //////////////////////////////////////////////////
  // Descriptor fields
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (tbl_wr_en) begin
      case (tbl_wr_field)
        reg_src[3:2]: req_mem[tbl_wr_idx].src <= tbl_wr_data;
        reg_dst[3:2]: req_mem[tbl_wr_idx].dst <= tbl_wr_data;
        reg_len[3:2]: req_mem[tbl_wr_idx].len <= tbl_wr_data[dma_len_w-1:0];  // Upper bits dropped
        default: ;  // Control goes to the flags
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Valid and done flags
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      done_q  <= '0;
    end else begin
      if (done_en) begin
        valid_q[done_idx] <= 1'b0;  // Engine retires entry
        done_q[done_idx]  <= 1'b1;
      end
      if (ctrl_wr && tbl_wr_data[ctrl_clear]) begin
        done_q[tbl_wr_idx] <= 1'b0;  // Ack from software
      end
      if (ctrl_wr && tbl_wr_data[ctrl_start]) begin
        valid_q[tbl_wr_idx] <= 1'b1;  // Software write wins a same-cycle retire
        done_q[tbl_wr_idx]  <= 1'b0;
      end
    end
  end

  assign tbl_rd_req   = req_mem[tbl_rd_idx];
  assign tbl_rd_flags = {done_q[tbl_rd_idx], valid_q[tbl_rd_idx]};  // Done in bit 1
  assign sel_req      = req_mem[sel_idx];
  assign valid        = valid_q;
  assign irq          = done_q;  // One line per entry

  // The engine only retires an entry it picked from the valid set
  a_done_on_valid: assert property (@(posedge clk) disable iff (rst)
    done_en |-> valid_q[done_idx])
    else $error("done_en for an entry that is not valid");

endmodule

/* hw/dma_top.sv */
`timescale 1ns/1ns
// Config slave answers with zero wait states and the memory master issues one word at a time
module dma_top import dma_pkg::*; #(
  parameter int TABLE_ENTRIES = 4
) (
  input  logic                     clk,
  input  logic                     rst,
  input  ahb_req_t                 cfg_req,
  output dma_data_t                cfg_hrdata,
  output logic                     cfg_hready,
  output ahb_req_t                 mem_req,
  input  dma_data_t                mem_hrdata,
  input  logic                     mem_hready,
  output logic [TABLE_ENTRIES-1:0] irq
);

  localparam int idx_w = (TABLE_ENTRIES > 1) ? $clog2(TABLE_ENTRIES) : 1;

  //////////////////////////////////////////////////
  // Internal nets
  //////////////////////////////////////////////////

  logic                     tbl_wr_en;     // Slave to table
  logic [idx_w-1:0]         tbl_wr_idx;
  logic [1:0]               tbl_wr_field;
  dma_data_t                tbl_wr_data;
  logic [idx_w-1:0]         tbl_rd_idx;
  dma_req_t                 tbl_rd_req;    // Table to slave
  logic [1:0]               tbl_rd_flags;
  logic [idx_w-1:0]         sel_idx;       // FSM to table
  dma_req_t                 sel_req;
  logic [TABLE_ENTRIES-1:0] valid;
  logic                     done_en;
  logic [idx_w-1:0]         done_idx;
  logic                     cnt_load;      // FSM to counter
  logic                     cnt_dec;
  logic                     cnt_zero;
  logic                     xfer_start;    // FSM to master
  logic                     xfer_write;
  dma_addr_t                xfer_addr;
  dma_data_t                xfer_wdata;
  logic                     xfer_done;
  dma_data_t                xfer_rdata;

  dma_cfg_slave #(.TABLE_ENTRIES(TABLE_ENTRIES)) cfg_slave (
    .clk, .rst, .cfg_req, .cfg_hrdata, .cfg_hready,
    .tbl_wr_en, .tbl_wr_idx, .tbl_wr_field, .tbl_wr_data,
    .tbl_rd_idx, .tbl_rd_req, .tbl_rd_flags
  );

  dma_request_table #(.TABLE_ENTRIES(TABLE_ENTRIES)) request_table (
    .clk, .rst, .tbl_wr_en, .tbl_wr_idx, .tbl_wr_field, .tbl_wr_data,
    .tbl_rd_idx, .tbl_rd_req, .tbl_rd_flags,
    .sel_idx, .sel_req, .valid, .done_en, .done_idx, .irq
  );

  dma_ctrl_fsm #(.TABLE_ENTRIES(TABLE_ENTRIES)) ctrl_fsm (
    .clk, .rst, .valid, .sel_idx, .sel_req, .cnt_load, .cnt_dec, .cnt_zero,
    .xfer_start, .xfer_write, .xfer_addr, .xfer_wdata, .xfer_done, .xfer_rdata,
    .done_en, .done_idx
  );

  dma_word_counter word_counter (
    .clk, .rst, .load(cnt_load), .len(sel_req.len), .dec(cnt_dec), .zero(cnt_zero)
  );

  dma_ahb_master ahb_master (
    .clk, .rst, .start(xfer_start), .write(xfer_write), .addr(xfer_addr),
    .wdata(xfer_wdata), .done(xfer_done), .rdata(xfer_rdata),
    .mem_req, .mem_hrdata, .mem_hready
  );

endmodule

/* verif/dma_mem_model.sv */
// Behavioural 1 KB AHB-Lite memory with no error response; addresses wrap at 0x400
`timescale 1ns/1ns
module dma_mem_model import dma_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      stall,       // Wait state request for this cycle
  input  ahb_req_t  mem_req,
  output dma_data_t mem_hrdata,
  output logic      mem_hready
);

  logic [31:0] mem [256];  // Word array, loaded and checked by the testbench
  logic        dp_valid;   // Data phase in progress
  logic        dp_write;
  logic [7:0]  dp_idx;     // Word index of the data phase

  assign mem_hready = !stall;  // Stall stretches either phase
  assign mem_hrdata = (dp_valid && !dp_write) ? mem[dp_idx] : '0;

  //////////////////////////////////////////////////
  // Address and data phases
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      dp_valid <= 1'b0;
    end else if (mem_hready) begin
      if (dp_valid && dp_write) begin
        mem[dp_idx] = mem_req.hwdata;  // Write data phase completes
      end
      dp_valid <= mem_req.hsel && (mem_req.htrans == htrans_nonseq);
      dp_write <= mem_req.hwrite;
      dp_idx   <= mem_req.haddr[9:2];  // Byte to word address
    end
  end

endmodule

/* verif/dma_tb.sv */
// Four table entries, memory below byte 0x400, and cases with one name run together as one test
`timescale 1ns/1ns
module dma_tb import dma_pkg::*; ();

  localparam int entries     = 4;
  localparam int mem_words   = 256;   // Size of the memory model
  localparam int irq_timeout = 5000;  // Cycles allowed per test
  localparam int rdy_timeout = 16;    // Cycles allowed for config hready

  logic               clk;
  logic               rst;
  ahb_req_t           cfg_req;
  dma_data_t          cfg_hrdata;
  logic               cfg_hready;
  ahb_req_t           mem_req;
  dma_data_t          mem_hrdata;
  logic               mem_hready;
  logic [entries-1:0] irq;
  logic               stall;                // Memory wait state
  logic               wait_mode;            // Random stalls on
  logic [31:0]        lfsr;
  logic [31:0]        ref_mem [mem_words];  // Expected memory image
  int                 err_cnt;
  int                 tests_run;
  int                 tests_bad;
  logic               timed_out;

  // Case table, one element per file line
  string       names [$];
  logic [31:0] waits_q [$];
  logic [31:0] entry_q [$];
  logic [31:0] src_q [$];
  logic [31:0] dst_q [$];
  logic [31:0] len_q [$];
  logic [31:0] seed_q [$];

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  dma_top #(.TABLE_ENTRIES(entries)) dut0 (
    .clk, .rst, .cfg_req, .cfg_hrdata, .cfg_hready,
    .mem_req, .mem_hrdata, .mem_hready, .irq
  );

  dma_mem_model mem0 (.clk, .rst, .stall, .mem_req, .mem_hrdata, .mem_hready);

  //////////////////////////////////////////////////
  // Random bits and checks
  //////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);     // One step per bit
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check_eq(input string tname, input string what,
                          input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("ERR %s %s expected %h actual %h", tname, what, exp, act);
    end
  endtask

  // Falling edge, new stall bit when enabled
  task automatic tick();
    logic [31:0] b;
    @(negedge clk);
    if (wait_mode) begin
      take_bits(1, b);
      stall = b[0];
    end else begin
      stall = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // Config bus access
  //////////////////////////////////////////////////

  task automatic wait_cfg_ready();
    int n;
    n = 0;
    while (!cfg_hready && n < rdy_timeout) begin
      tick();
      n++;
    end
    if (!cfg_hready) begin
      $display("config slave kept hready low for %0d cycles", rdy_timeout);
      timed_out = 1'b1;
    end
  endtask

  task automatic cfg_write(input logic [31:0] addr, input logic [31:0] data);
    tick();
    cfg_req.hsel   = 1'b1;  // Address phase
    cfg_req.htrans = htrans_nonseq;
    cfg_req.haddr  = addr;
    cfg_req.hwrite = 1'b1;
    tick();
    cfg_req.hsel   = 1'b0;  // Data phase, bus idle behind it
    cfg_req.htrans = htrans_idle;
    cfg_req.hwdata = data;
    wait_cfg_ready();
  endtask

  task automatic cfg_read(input logic [31:0] addr, output logic [31:0] data);
    tick();
    cfg_req.hsel   = 1'b1;
    cfg_req.htrans = htrans_nonseq;
    cfg_req.haddr  = addr;
    cfg_req.hwrite = 1'b0;
    tick();
    cfg_req.hsel   = 1'b0;
    cfg_req.htrans = htrans_idle;
    wait_cfg_ready();
    data = cfg_hrdata;  // Read data in the data phase
  endtask

  task automatic wait_irq(input logic [entries-1:0] mask, input string tname);
    int n;
    n = 0;
    while ((irq & mask) != mask && n < irq_timeout) begin
      tick();
      n++;
    end
    if ((irq & mask) != mask) begin
      $display("%s: irq %b did not all rise within %0d cycles", tname, mask, irq_timeout);
      timed_out = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////
  // Memory image
  //////////////////////////////////////////////////

  task automatic fill_memory(input logic [31:0] seed);
    logic [31:0] b;
    for (int i = 0; i < mem_words; i++) begin
      take_bits(32, b);
      mem0.mem[i] = b ^ seed ^ (32'(i) << 2);  // Byte address mixed in
      ref_mem[i]  = mem0.mem[i];
    end
  endtask

  // Word by word, source read before destination write
  task automatic copy_reference(input logic [31:0] src, input logic [31:0] dst,
                                input logic [31:0] len);
    int s;
    int d;
    s = int'(src >> 2);
    d = int'(dst >> 2);
    for (int k = 0; k < int'(len); k++) begin
      ref_mem[(d + k) % mem_words] = ref_mem[(s + k) % mem_words];
    end
  endtask

  task automatic compare_memory(input string tname);
    for (int i = 0; i < mem_words; i++) begin
      check_eq(tname, $sformatf("mem[%03h]", i * 4), ref_mem[i], mem0.mem[i]);
    end
  endtask

  //////////////////////////////////////////////////
  // One test per group of case lines
  //////////////////////////////////////////////////

  task automatic run_group(input int first, input int last);
    string              tname;
    logic [31:0]        rd;
    logic [31:0]        base;
    logic [entries-1:0] mask;
    int                 errs_before;
    tname       = names[first];
    errs_before = err_cnt;
    mask        = '0;
    wait_mode   = 1'b0;
    fill_memory(seed_q[first]);
    wait_mode = (waits_q[first] != 0);
    for (int i = first; i <= last; i++) begin
      base = entry_q[i] << 4;  // 16-byte window per entry
      mask[entry_q[i]] = 1'b1;
      cfg_write(base + 32'(reg_src), src_q[i]);
      cfg_write(base + 32'(reg_dst), dst_q[i]);
      cfg_write(base + 32'(reg_len), len_q[i]);
      cfg_read(base + 32'(reg_src), rd);
      check_eq(tname, "src readback", src_q[i], rd);
      cfg_read(base + 32'(reg_dst), rd);
      check_eq(tname, "dst readback", dst_q[i], rd);
      cfg_read(base + 32'(reg_len), rd);
      check_eq(tname, "len readback", len_q[i], rd);
      cfg_read(base + 32'(reg_ctrl), rd);
      check_eq(tname, "ctrl before start", 32'h0, rd);
    end
    for (int i = first; i <= last; i++) begin
      cfg_write((entry_q[i] << 4) + 32'(reg_ctrl), 32'h1 << ctrl_start);
      copy_reference(src_q[i], dst_q[i], len_q[i]);
    end
    wait_irq(mask, tname);
    if (!timed_out) begin
      for (int i = first; i <= last; i++) begin
        cfg_read((entry_q[i] << 4) + 32'(reg_ctrl), rd);
        check_eq(tname, "ctrl after irq", 32'h2, rd);  // Done set, valid clear
      end
      compare_memory(tname);
      for (int i = first; i <= last; i++) begin
        cfg_write((entry_q[i] << 4) + 32'(reg_ctrl), 32'h1 << ctrl_clear);
      end
      tick();
      check_eq(tname, "irq after clear", 32'h0, 32'(irq & mask));
      for (int i = first; i <= last; i++) begin
        cfg_read((entry_q[i] << 4) + 32'(reg_ctrl), rd);
        check_eq(tname, "ctrl after clear", 32'h0, rd);
      end
    end
    wait_mode = 1'b0;
    tests_run++;
    if (err_cnt != errs_before || timed_out) begin
      tests_bad++;
    end
    $display("%s: %0d errors", tname, err_cnt - errs_before);
  endtask

  initial begin
    int          fd;
    int          first;
    int          last;
    string       line;
    string       nm;
    logic [31:0] w;
    logic [31:0] e;
    logic [31:0] s;
    logic [31:0] d;
    logic [31:0] l;
    logic [31:0] sd;
    rst       = 1'b1;
    cfg_req   = '0;  // Idle bus, hsel low
    stall     = 1'b0;
    wait_mode = 1'b0;
    lfsr      = 32'ha32e;
    err_cnt   = 0;
    tests_run = 0;
    tests_bad = 0;
    timed_out = 1'b0;
    fd = $fopen("verif/dma_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open verif/dma_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#" &&
            $sscanf(line, "%s %h %h %h %h %h %h", nm, w, e, s, d, l, sd) == 7) begin
          names.push_back(nm);
          waits_q.push_back(w);
          entry_q.push_back(e);
          src_q.push_back(s);
          dst_q.push_back(d);
          len_q.push_back(l);
          seed_q.push_back(sd);
        end
      end
      $fclose(fd);
    end
    repeat (5) @(negedge clk);  // Reset for 5 cycles
    rst   = 1'b0;
    first = 0;
    while (first < names.size() && !timed_out) begin
      last = first;
      while (last + 1 < names.size() && names[last + 1] == names[first]) begin
        last++;  // Same name, same test
      end
      run_group(first, last);
      first = last + 1;
    end
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_bad, err_cnt);
    if (tests_run > 0 && tests_bad == 0 && err_cnt == 0 && !timed_out) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* verif/dma_cases.txt */
# name waits entry src dst len seed, numbers in hex, byte addresses below 400
# consecutive lines with one name start together; waits 1 turns on random hready low
readback_single 0 0 000 200 4 1a2b
single_entry3 0 3 040 280 8 77
single_long 0 1 100 300 20 4c1d
queued_all 0 0 000 200 5 c3
queued_all 0 1 020 240 3 c3
queued_all 0 2 080 280 10 c3
queued_all 0 3 100 300 7 c3
queued_pair 0 3 010 210 2 e5
queued_pair 0 1 0c0 2c0 9 e5
waits_single 1 1 010 210 6 5e
waits_queued 1 0 000 200 8 91
waits_queued 1 2 040 260 4 91
waits_queued 1 3 120 320 12 91
zero_len 0 2 050 250 0 0d
zero_len_waits 1 0 060 270 0 2f

/* compile.f */
common/dma_pkg.sv
dma_engine/dma_word_counter.sv
dma_engine/dma_ahb_master.sv
dma_engine/dma_ctrl_fsm.sv
hw/dma_cfg_slave.sv
hw/dma_request_table.sv
hw/dma_top.sv
verif/dma_mem_model.sv
verif/dma_tb.sv
